//--- source/colorConvert_config.svh
`ifndef COLOR_CONVERT_CONFIG_SVH
`define COLOR_CONVERT_CONFIG_SVH

// Image geometry in pixels, width must be a multiple of 4
`define CC_IMAGE_WIDTH 16
`define CC_IMAGE_HEIGHT 4

// Word addresses of the four SRAM regions

// Two Y samples per word, row-major
`define CC_Y_BASE 18'h00000

// Two chroma samples per word, half the width per row
`define CC_U_BASE 18'h08000
`define CC_V_BASE 18'h0C000

// Three packed RGB words per pixel pair
`define CC_RGB_BASE 18'h10000

// Cycles from address to read data
`define CC_READ_LATENCY 2

`endif

//--- source/colorConvertPkg.sv
package colorConvertPkg;

	// One 8-bit unsigned image sample
	typedef logic [7:0] sampleByte;

	// SRAM data word, high byte holds the even (earlier) sample
	typedef logic [15:0] sramWord;

	// SRAM word address
	typedef logic [17:0] sramAddress;

	// Frame sequencing states
	typedef enum logic [1:0] {
		Idle,
		LeadIn,
		PairLoop,
		Drain
	} controlState;

	// Saturate a signed result to the 0..255 sample range
	function automatic sampleByte clipToByte(input logic signed [31:0] value);
		sampleByte result;
		if (value < 0) begin
			result = 8'd0;
		end else if (value > 32'sd255) begin
			result = 8'd255;
		end else begin
			result = value[7:0];
		end
		return result;
	endfunction

endpackage

//--- source/chromaInterpolator.sv
module chromaInterpolator (
	input logic Clock,
	input logic Resetn,
	input logic LoadRow,
	input logic Shift,
	input colorConvertPkg::sampleByte Sample,
	output colorConvertPkg::sampleByte Centre,
	output colorConvertPkg::sampleByte OddSample
);

	// Window taps 0..5, tap 2 is the even sample of the current pair
	colorConvertPkg::sampleByte window [0:5];

	logic signed [31:0] outerSum;
	logic signed [31:0] innerSum;
	logic signed [31:0] centreSum;
	logic signed [31:0] filterSum;

	// With LoadRow a shift replicates the row's edge sample into every tap
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < 6; i++) begin
				window[i] <= '0;
			end
		end else if (Shift) begin
			if (LoadRow) begin
				for (int i = 0; i < 6; i++) begin
					window[i] <= Sample;
				end
			end else begin
				for (int i = 0; i < 5; i++) begin
					window[i] <= window[i+1];
				end
				window[5] <= Sample;
			end
		end
	end

	// Symmetric taps share one multiply
	assign outerSum = $signed({24'd0, window[0]}) + $signed({24'd0, window[5]});
	assign innerSum = $signed({24'd0, window[1]}) + $signed({24'd0, window[4]});
	assign centreSum = $signed({24'd0, window[2]}) + $signed({24'd0, window[3]});

	// Taps 21, -52, 159 sum to 256, so rounding adds half of that
	assign filterSum = 32'sd21 * outerSum - 32'sd52 * innerSum
		+ 32'sd159 * centreSum + 32'sd128;

	assign OddSample = colorConvertPkg::clipToByte(filterSum >>> 8);
	assign Centre = window[2];

endmodule

//--- source/colorMatrix.sv
module colorMatrix (
	input logic Clock,
	input logic Resetn,
	input logic ConvertEven,
	input logic ConvertOdd,
	input colorConvertPkg::sramWord Luma,
	input colorConvertPkg::sramWord ChromaU,
	input colorConvertPkg::sramWord ChromaV,
	output colorConvertPkg::sampleByte Red,
	output colorConvertPkg::sampleByte Green,
	output colorConvertPkg::sampleByte Blue,
	output logic ResultValid
);

	// Odd Y kept from the word seen at the even conversion
	colorConvertPkg::sampleByte lumaOdd;
	colorConvertPkg::sampleByte luma;
	colorConvertPkg::sampleByte chromaU;
	colorConvertPkg::sampleByte chromaV;

	logic signed [31:0] lumaTerm;
	logic signed [31:0] uOffset;
	logic signed [31:0] vOffset;
	logic signed [31:0] redSum;
	logic signed [31:0] greenSum;
	logic signed [31:0] blueSum;

	// Even pixel takes the centre chroma, odd takes the interpolated one
	assign luma = ConvertOdd ? lumaOdd : Luma[15:8];
	assign chromaU = ConvertOdd ? ChromaU[7:0] : ChromaU[15:8];
	assign chromaV = ConvertOdd ? ChromaV[7:0] : ChromaV[15:8];

	assign lumaTerm = 32'sd76284 * ($signed({24'd0, luma}) - 32'sd16);
	assign uOffset = $signed({24'd0, chromaU}) - 32'sd128;
	assign vOffset = $signed({24'd0, chromaV}) - 32'sd128;

	// Coefficients in 16-bit fixed point
	assign redSum = lumaTerm + 32'sd104595 * vOffset;
	assign greenSum = lumaTerm - 32'sd25624 * uOffset - 32'sd53281 * vOffset;
	assign blueSum = lumaTerm + 32'sd132251 * uOffset;

	always_ff @(posedge Clock) begin
		if (ConvertEven) begin
			lumaOdd <= Luma[7:0];
		end
		if (ConvertEven || ConvertOdd) begin
			Red <= colorConvertPkg::clipToByte(redSum >>> 16);
			Green <= colorConvertPkg::clipToByte(greenSum >>> 16);
			Blue <= colorConvertPkg::clipToByte(blueSum >>> 16);
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			ResultValid <= 1'b0;
		end else begin
			ResultValid <= ConvertEven || ConvertOdd;
		end
	end

endmodule

//--- source/rgbWordPacker.sv
module rgbWordPacker (
	input logic Clock,
	input logic Resetn,
	input colorConvertPkg::sampleByte Red,
	input colorConvertPkg::sampleByte Green,
	input colorConvertPkg::sampleByte Blue,
	input logic ResultValid,
	input logic PairLoad,
	input logic [1:0] WordSelect,
	output colorConvertPkg::sramWord SramWriteData
);

	// Next result goes to the odd slot
	logic takeOdd;

	// Pair being computed
	colorConvertPkg::sampleByte red0;
	colorConvertPkg::sampleByte green0;
	colorConvertPkg::sampleByte blue0;
	colorConvertPkg::sampleByte red1;
	colorConvertPkg::sampleByte green1;
	colorConvertPkg::sampleByte blue1;

	// Pair being written
	colorConvertPkg::sramWord holdWord0;
	colorConvertPkg::sramWord holdWord1;
	colorConvertPkg::sramWord holdWord2;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			takeOdd <= 1'b0;
		end else if (ResultValid) begin
			takeOdd <= ~takeOdd;
		end
	end

	always_ff @(posedge Clock) begin
		if (ResultValid && !takeOdd) begin
			red0 <= Red;
			green0 <= Green;
			blue0 <= Blue;
		end
		if (ResultValid && takeOdd) begin
			red1 <= Red;
			green1 <= Green;
			blue1 <= Blue;
		end
		// Packed by field position, first sample in the high byte
		if (PairLoad) begin
			holdWord0 <= {red0, green0};
			holdWord1 <= {blue0, red1};
			holdWord2 <= {green1, blue1};
		end
	end

	always_comb begin
		case (WordSelect)
			2'd0: SramWriteData = holdWord0;
			2'd1: SramWriteData = holdWord1;
			default: SramWriteData = holdWord2;
		endcase
	end

endmodule

//--- source/conversionControl.sv
`include "colorConvert_config.svh"

module conversionControl (
	input logic Clock,
	input logic Resetn,
	input logic Start,
	input logic ResultValid,
	output logic Busy,
	output logic Done,
	output colorConvertPkg::sramAddress SramAddress,
	output logic SramWriteN,
	output logic UShift,
	output logic VShift,
	output logic LoadRow,
	output logic ConvertEven,
	output logic ConvertOdd,
	output logic PairLoad,
	output logic [1:0] WordSelect,
	output logic ReadByteSelect
);

	localparam int pairsPerRow = `CC_IMAGE_WIDTH / 2;
	localparam int chromaWordsPerRow = `CC_IMAGE_WIDTH / 4;
	localparam int readLatency = `CC_READ_LATENCY;

	colorConvertPkg::controlState state;
	logic [3:0] phase;
	logic [15:0] columnCount;
	logic [15:0] rowCount;
	colorConvertPkg::sramAddress yCount;
	colorConvertPkg::sramAddress chromaRowBase;
	colorConvertPkg::sramAddress rgbCount;
	colorConvertPkg::sramAddress chromaAddress;
	logic havePair;
	logic oddResult;

	logic issueY;
	logic issueU;
	logic issueV;
	logic issueLoad;
	logic writeActive;
	logic [15:0] sampleWanted;
	logic [15:0] sampleIndex;

	// Strobes delayed to meet the read data
	logic [readLatency-1:0] yPipe;
	logic [readLatency-1:0] uPipe;
	logic [readLatency-1:0] vPipe;
	logic [readLatency-1:0] loadPipe;
	logic [readLatency-1:0] bytePipe;

	// Chroma sample to fetch, clamped to the last one of the row
	always_comb begin
		if (state == colorConvertPkg::LeadIn) begin
			sampleWanted = {13'd0, phase[3:1]};
		end else begin
			sampleWanted = columnCount + 16'd4;
		end
		if (sampleWanted > 16'(pairsPerRow - 1)) begin
			sampleIndex = 16'(pairsPerRow - 1);
		end else begin
			sampleIndex = sampleWanted;
		end
	end

	assign chromaAddress = chromaRowBase + colorConvertPkg::sramAddress'(sampleIndex >> 1);

	// Loop phases 0..2 read Y, U, V and phases 3..5 write the previous pair
	always_comb begin
		issueY = 1'b0;
		issueU = 1'b0;
		issueV = 1'b0;
		issueLoad = 1'b0;
		writeActive = 1'b0;
		case (state)
			colorConvertPkg::LeadIn: begin
				if (phase < 4'd8) begin
					issueU = ~phase[0];
					issueV = phase[0];
					issueLoad = (phase < 4'd2);
				end
			end
			colorConvertPkg::PairLoop: begin
				issueY = (phase == 4'd0);
				issueU = (phase == 4'd1);
				issueV = (phase == 4'd2);
				writeActive = havePair && (phase >= 4'd3);
			end
			colorConvertPkg::Drain: begin
				writeActive = 1'b1;
			end
			default: begin
			end
		endcase

		if (issueU) begin
			SramAddress = `CC_U_BASE + chromaAddress;
		end else if (issueV) begin
			SramAddress = `CC_V_BASE + chromaAddress;
		end else if (writeActive) begin
			SramAddress = `CC_RGB_BASE + rgbCount;
		end else begin
			SramAddress = `CC_Y_BASE + yCount;
		end
	end

	assign SramWriteN = ~writeActive;
	assign WordSelect = 2'(phase - 4'd3);

	assign ConvertEven = yPipe[readLatency-1];
	assign UShift = uPipe[readLatency-1];
	assign VShift = vPipe[readLatency-1];
	assign LoadRow = loadPipe[readLatency-1];
	assign ReadByteSelect = bytePipe[readLatency-1];

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			yPipe <= '0;
			uPipe <= '0;
			vPipe <= '0;
			loadPipe <= '0;
			bytePipe <= '0;
			ConvertOdd <= 1'b0;
			PairLoad <= 1'b0;
			oddResult <= 1'b0;
		end else begin
			yPipe[0] <= issueY;
			uPipe[0] <= issueU;
			vPipe[0] <= issueV;
			loadPipe[0] <= issueLoad;
			bytePipe[0] <= sampleIndex[0];
			for (int i = 1; i < readLatency; i++) begin
				yPipe[i] <= yPipe[i-1];
				uPipe[i] <= uPipe[i-1];
				vPipe[i] <= vPipe[i-1];
				loadPipe[i] <= loadPipe[i-1];
				bytePipe[i] <= bytePipe[i-1];
			end
			// Odd pixel converts the cycle after the even one
			ConvertOdd <= ConvertEven;
			if (ResultValid) begin
				oddResult <= ~oddResult;
			end
			// Both results of the pair are in the packer
			PairLoad <= ResultValid && oddResult;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= colorConvertPkg::Idle;
			phase <= 4'd0;
			columnCount <= 16'd0;
			rowCount <= 16'd0;
			yCount <= '0;
			chromaRowBase <= '0;
			rgbCount <= '0;
			havePair <= 1'b0;
			Busy <= 1'b0;
			Done <= 1'b0;
		end else begin
			Done <= 1'b0;
			case (state)
				colorConvertPkg::Idle: begin
					if (Start) begin
						state <= colorConvertPkg::LeadIn;
						phase <= 4'd0;
						columnCount <= 16'd0;
						rowCount <= 16'd0;
						yCount <= '0;
						chromaRowBase <= '0;
						rgbCount <= '0;
						havePair <= 1'b0;
						Busy <= 1'b1;
					end
				end
				colorConvertPkg::LeadIn: begin
					// Last lead-in sample arrives in phase 9
					if (phase == 4'd9) begin
						state <= colorConvertPkg::PairLoop;
						phase <= 4'd0;
					end else begin
						phase <= phase + 4'd1;
					end
				end
				colorConvertPkg::PairLoop: begin
					if (phase == 4'd0) begin
						yCount <= yCount + 18'd1;
					end
					if (writeActive) begin
						rgbCount <= rgbCount + 18'd1;
					end
					if (phase == 4'd5) begin
						havePair <= 1'b1;
						phase <= 4'd0;
						if (columnCount == 16'(pairsPerRow - 1)) begin
							columnCount <= 16'd0;
							if (rowCount == 16'(`CC_IMAGE_HEIGHT - 1)) begin
								state <= colorConvertPkg::Drain;
								phase <= 4'd3;
							end else begin
								rowCount <= rowCount + 16'd1;
								chromaRowBase <= chromaRowBase + 18'(chromaWordsPerRow);
								state <= colorConvertPkg::LeadIn;
							end
						end else begin
							columnCount <= columnCount + 16'd1;
						end
					end else begin
						phase <= phase + 4'd1;
					end
				end
				colorConvertPkg::Drain: begin
					// Writes of the final pair
					rgbCount <= rgbCount + 18'd1;
					if (phase == 4'd5) begin
						state <= colorConvertPkg::Idle;
						Busy <= 1'b0;
						Done <= 1'b1;
					end else begin
						phase <= phase + 4'd1;
					end
				end
				default: begin
					state <= colorConvertPkg::Idle;
				end
			endcase
		end
	end

endmodule

//--- source/colorConvertTop.sv
module colorConvertTop (
	input logic Clock,
	input logic Resetn,
	input logic Start,
	output logic Busy,
	output logic Done,
	output colorConvertPkg::sramAddress SramAddress,
	input colorConvertPkg::sramWord SramReadData,
	output colorConvertPkg::sramWord SramWriteData,
	output logic SramWriteN
);

	logic uShift;
	logic vShift;
	logic loadRow;
	logic convertEven;
	logic convertOdd;
	logic pairLoad;
	logic [1:0] wordSelect;
	logic readByteSelect;
	logic resultValid;
	colorConvertPkg::sampleByte chromaSample;
	colorConvertPkg::sampleByte uCentre;
	colorConvertPkg::sampleByte uOdd;
	colorConvertPkg::sampleByte vCentre;
	colorConvertPkg::sampleByte vOdd;
	colorConvertPkg::sampleByte red;
	colorConvertPkg::sampleByte green;
	colorConvertPkg::sampleByte blue;

	// Chroma byte picked out of the arriving read word
	assign chromaSample = readByteSelect ? SramReadData[7:0] : SramReadData[15:8];

	conversionControl control (
		.Clock(Clock),
		.Resetn(Resetn),
		.Start(Start),
		.ResultValid(resultValid),
		.Busy(Busy),
		.Done(Done),
		.SramAddress(SramAddress),
		.SramWriteN(SramWriteN),
		.UShift(uShift),
		.VShift(vShift),
		.LoadRow(loadRow),
		.ConvertEven(convertEven),
		.ConvertOdd(convertOdd),
		.PairLoad(pairLoad),
		.WordSelect(wordSelect),
		.ReadByteSelect(readByteSelect)
	);

	chromaInterpolator uChannel (
		.Clock(Clock),
		.Resetn(Resetn),
		.LoadRow(loadRow),
		.Shift(uShift),
		.Sample(chromaSample),
		.Centre(uCentre),
		.OddSample(uOdd)
	);

	chromaInterpolator vChannel (
		.Clock(Clock),
		.Resetn(Resetn),
		.LoadRow(loadRow),
		.Shift(vShift),
		.Sample(chromaSample),
		.Centre(vCentre),
		.OddSample(vOdd)
	);

	// Chroma pairs travel as {centre, interpolated}
	colorMatrix matrix (
		.Clock(Clock),
		.Resetn(Resetn),
		.ConvertEven(convertEven),
		.ConvertOdd(convertOdd),
		.Luma(SramReadData),
		.ChromaU({uCentre, uOdd}),
		.ChromaV({vCentre, vOdd}),
		.Red(red),
		.Green(green),
		.Blue(blue),
		.ResultValid(resultValid)
	);

	rgbWordPacker packer (
		.Clock(Clock),
		.Resetn(Resetn),
		.Red(red),
		.Green(green),
		.Blue(blue),
		.ResultValid(resultValid),
		.PairLoad(pairLoad),
		.WordSelect(wordSelect),
		.SramWriteData(SramWriteData)
	);

endmodule

//--- tests/sramModel.sv
`include "colorConvert_config.svh"

module sramModel (
	input logic Clock,
	input colorConvertPkg::sramAddress Address,
	input colorConvertPkg::sramWord WriteData,
	input logic WriteN,
	output colorConvertPkg::sramWord ReadData
);

	localparam int depth = 1 << 18;
	localparam int latency = `CC_READ_LATENCY;

	colorConvertPkg::sramWord memory [0:depth-1];
	colorConvertPkg::sramWord readPipe [0:latency-1];

	// Background pattern so stray reads are easy to spot
	initial begin
		for (int a = 0; a < depth; a++) begin
			memory[a] = 16'(a) ^ 16'(a >> 16) ^ 16'h3C5A;
		end
	end

	// Read data comes out latency cycles after its address
	always @(posedge Clock) begin
		readPipe[0] <= memory[Address];
		for (int i = 1; i < latency; i++) begin
			readPipe[i] <= readPipe[i-1];
		end
		if (!WriteN) begin
			memory[Address] = WriteData;
		end
	end

	assign ReadData = readPipe[latency-1];

	task automatic preloadWord(input colorConvertPkg::sramAddress address,
		input colorConvertPkg::sramWord data);
		memory[address] = data;
	endtask

	task automatic dumpWord(input colorConvertPkg::sramAddress address,
		output colorConvertPkg::sramWord data);
		data = memory[address];
	endtask

endmodule

//--- tests/colorConvertTb.sv
`include "colorConvert_config.svh"

module colorConvertTb;

	localparam int width = `CC_IMAGE_WIDTH;
	localparam int height = `CC_IMAGE_HEIGHT;
	localparam int pairsPerRow = width / 2;
	localparam int totalWrites = width * height * 3 / 2;
	localparam int frameTimeout = 100 * width * height;

	logic Clock;
	logic Resetn;
	logic Start;
	logic Busy;
	logic Done;
	colorConvertPkg::sramAddress SramAddress;
	colorConvertPkg::sramWord SramReadData;
	colorConvertPkg::sramWord SramWriteData;
	logic SramWriteN;

	integer seed;
	colorConvertPkg::sampleByte yPlane [0:height-1][0:width-1];
	colorConvertPkg::sampleByte uPlane [0:height-1][0:pairsPerRow-1];
	colorConvertPkg::sampleByte vPlane [0:height-1][0:pairsPerRow-1];
	colorConvertPkg::sramWord expectedWords [0:totalWrites-1];
	int writeCount;
	int doneCount;

	colorConvertTop i_colorConvertTop (
		.Clock(Clock),
		.Resetn(Resetn),
		.Start(Start),
		.Busy(Busy),
		.Done(Done),
		.SramAddress(SramAddress),
		.SramReadData(SramReadData),
		.SramWriteData(SramWriteData),
		.SramWriteN(SramWriteN)
	);

	sramModel sram (
		.Clock(Clock),
		.Address(SramAddress),
		.WriteData(SramWriteData),
		.WriteN(SramWriteN),
		.ReadData(SramReadData)
	);

	always #50 Clock = ~Clock;

	task automatic reportFailure(input string message);
		$display("%s", message);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string signalName, input logic [31:0] expected,
		input logic [31:0] actual);
		reportFailure($sformatf("MISMATCH at time %0t: %s expected %0h actual %0h",
			$time, signalName, expected, actual));
	endtask

	function automatic colorConvertPkg::sramAddress offsetAddress(input int base, input int offset);
		return colorConvertPkg::sramAddress'(base + offset);
	endfunction

	function automatic bit inInputRegion(input colorConvertPkg::sramAddress address);
		int a;
		a = int'(address);
		return (a >= int'(`CC_Y_BASE) && a < int'(`CC_Y_BASE) + width * height / 2)
			|| (a >= int'(`CC_U_BASE) && a < int'(`CC_U_BASE) + width * height / 4)
			|| (a >= int'(`CC_V_BASE) && a < int'(`CC_V_BASE) + width * height / 4);
	endfunction

	function automatic colorConvertPkg::sampleByte saturate(input int value);
		if (value < 0) begin
			return 8'd0;
		end
		if (value > 255) begin
			return 8'd255;
		end
		return value[7:0];
	endfunction

	// Chroma sample with its index held inside the row
	function automatic int chromaAt(input bit useV, input int row, input int index);
		int clamped;
		clamped = index < 0 ? 0 : (index > pairsPerRow - 1 ? pairsPerRow - 1 : index);
		return useV ? int'(vPlane[row][clamped]) : int'(uPlane[row][clamped]);
	endfunction

	// Odd chroma halfway between samples k and k+1
	function automatic int interpolateOdd(input bit useV, input int row, input int k);
		int sum;
		sum = 21 * (chromaAt(useV, row, k - 2) + chromaAt(useV, row, k + 3))
			- 52 * (chromaAt(useV, row, k - 1) + chromaAt(useV, row, k + 2))
			+ 159 * (chromaAt(useV, row, k) + chromaAt(useV, row, k + 1)) + 128;
		return int'(saturate(sum >>> 8));
	endfunction

	// Returns {R, G, B}
	function automatic logic [23:0] convertPixel(input int luma, input int u, input int v);
		int lumaPart;
		lumaPart = 76284 * (luma - 16);
		return {saturate((lumaPart + 104595 * (v - 128)) >>> 16),
			saturate((lumaPart - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16),
			saturate((lumaPart + 132251 * (u - 128)) >>> 16)};
	endfunction

	// Saturated images use only full-scale samples
	function automatic colorConvertPkg::sampleByte nextSample(input bit saturated);
		logic [7:0] raw;
		raw = 8'($random(seed));
		if (!saturated) begin
			return raw;
		end
		return raw[0] ? 8'd255 : 8'd0;
	endfunction

	task automatic makeImage(input bit saturated);
		for (int row = 0; row < height; row++) begin
			for (int col = 0; col < width; col++) begin
				yPlane[row][col] = nextSample(saturated);
			end
			for (int k = 0; k < pairsPerRow; k++) begin
				uPlane[row][k] = nextSample(saturated);
				vPlane[row][k] = nextSample(saturated);
			end
		end
	endtask

	task automatic storeImage();
		for (int row = 0; row < height; row++) begin
			for (int k = 0; k < pairsPerRow; k++) begin
				sram.preloadWord(offsetAddress(int'(`CC_Y_BASE), row * pairsPerRow + k),
					{yPlane[row][2*k], yPlane[row][2*k+1]});
			end
			for (int j = 0; j < width / 4; j++) begin
				sram.preloadWord(offsetAddress(int'(`CC_U_BASE), row * width / 4 + j),
					{uPlane[row][2*j], uPlane[row][2*j+1]});
				sram.preloadWord(offsetAddress(int'(`CC_V_BASE), row * width / 4 + j),
					{vPlane[row][2*j], vPlane[row][2*j+1]});
			end
		end
	endtask

	// Three words per pair in the order R0G0, B0R1, G1B1
	task automatic buildExpectedWords();
		int pair;
		logic [23:0] evenRgb;
		logic [23:0] oddRgb;
		pair = 0;
		for (int row = 0; row < height; row++) begin
			for (int k = 0; k < pairsPerRow; k++) begin
				evenRgb = convertPixel(int'(yPlane[row][2*k]), int'(uPlane[row][k]),
					int'(vPlane[row][k]));
				oddRgb = convertPixel(int'(yPlane[row][2*k+1]), interpolateOdd(1'b0, row, k),
					interpolateOdd(1'b1, row, k));
				expectedWords[3*pair] = evenRgb[23:8];
				expectedWords[3*pair+1] = {evenRgb[7:0], oddRgb[23:16]};
				expectedWords[3*pair+2] = oddRgb[15:0];
				pair++;
			end
		end
	endtask

	task automatic runFrame(input string label);
		int cycles;
		colorConvertPkg::sramWord stored;
		@(posedge Clock);
		Start <= 1'b1;
		@(posedge Clock);
		Start <= 1'b0;
		@(posedge Clock);
		assert (Busy) else reportFailure({"Busy did not rise after Start of the ", label, " frame"});
		cycles = 0;
		while (doneCount == 0 && cycles < frameTimeout) begin
			@(posedge Clock);
			cycles++;
		end
		assert (doneCount != 0)
			else reportFailure({"timed out waiting for Done of the ", label, " frame"});
		// Nothing may move once the frame is over
		for (int i = 0; i < 20; i++) begin
			assert (SramWriteN && !Busy && !Done && doneCount == 1)
				else reportFailure({"activity after Done of the ", label, " frame"});
			@(posedge Clock);
		end
		for (int i = 0; i < totalWrites; i++) begin
			sram.dumpWord(offsetAddress(int'(`CC_RGB_BASE), i), stored);
			assert (stored == expectedWords[i])
				else reportMismatch("stored RGB word", 32'(expectedWords[i]), 32'(stored));
		end
	endtask

	// Write and Done monitor sampling values as they stood before the edge
	always @(posedge Clock) begin
		colorConvertPkg::sramAddress expectedAddress;
		expectedAddress = offsetAddress(int'(`CC_RGB_BASE), writeCount);
		if (Start && !Busy) begin
			writeCount <= 0;
			doneCount <= 0;
		end
		if (!SramWriteN) begin
			assert (Busy && writeCount < totalWrites)
				else reportFailure("SRAM write outside a frame or past the last RGB word");
			assert (!inInputRegion(SramAddress))
				else reportFailure("SRAM write landed in the Y, U or V region");
			assert (SramAddress == expectedAddress)
				else reportMismatch("SramAddress", 32'(expectedAddress), 32'(SramAddress));
			assert (SramWriteData == expectedWords[writeCount])
				else reportMismatch("SramWriteData", 32'(expectedWords[writeCount]),
					32'(SramWriteData));
			writeCount <= writeCount + 1;
		end
		if (Done) begin
			assert (!Busy) else reportFailure("Busy did not fall together with Done");
			assert (writeCount == totalWrites)
				else reportMismatch("write count at Done", 32'(totalWrites), 32'(writeCount));
			doneCount <= doneCount + 1;
		end
	end

	initial begin
		seed = 32'h8387;
		Clock = 1'b0;
		Resetn <= 1'b0;
		Start <= 1'b0;
		repeat (2) @(posedge Clock);
		Resetn <= 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(posedge Clock);
			assert (SramWriteN && !Busy && !Done)
				else reportFailure("outputs not idle after reset");
		end
		makeImage(1'b0);
		storeImage();
		buildExpectedWords();
		runFrame("random");
		// Second frame drives both clipping limits
		makeImage(1'b1);
		storeImage();
		buildExpectedWords();
		runFrame("saturated");
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module colorConvertTb -o colorConvertSim

./obj_dir/colorConvertSim 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failure"

//--- all.f
+incdir+source
source/colorConvertPkg.sv
source/chromaInterpolator.sv
source/colorMatrix.sv
source/rgbWordPacker.sv
source/conversionControl.sv
source/colorConvertTop.sv
tests/sramModel.sv
tests/colorConvertTb.sv
